// File: source/idu_cfg.svh
// decode stage configuration: widths, RV32I opcodes, ALU codes and writeback selects
`ifndef IDU_CFG_SVH
`define IDU_CFG_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define NUM_SRC     2

// major opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_IMM      7'b0010011
`define OP_REG      7'b0110011
`define OP_SYSTEM   7'b1110011

// ALU operation codes
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9
// src2 straight through for lui
`define ALU_IMM     4'd10

// writeback data select
`define WD_ALU      2'd0
`define WD_MEM      2'd1
`define WD_PC4      2'd2

`define INST_EBREAK 32'h0010_0073

`endif

// File: source/decode_pkg.sv
// decode package: field types, control and output structs, output stage state
`default_nettype none

`include "idu_cfg.svh"

package decode_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0]            inst_t;
  typedef logic [3:0]             alu_op_t;
  typedef logic [1:0]             wd_sel_t;
  typedef logic [3:0]             wmask_t;
  typedef logic [2:0]             funct3_t;

  typedef struct packed {
    alu_op_t alu_op;
    wd_sel_t wd_sel;
    logic    reg_we;
    logic    mem_ren;
    logic    mem_wen;
    wmask_t  wmask;
    logic    load_signed;
    logic    ebreak;
  } ctrl_t;

  typedef struct packed {
    word_t     pc;
    reg_addr_t rd;
    word_t     imm;
    word_t     src1;
    word_t     src2;
    ctrl_t     ctrl;
    word_t     pc_next;
  } decode_out_t;

  typedef enum logic {
    IDLE,
    FULL
  } stage_state_e;

endpackage

`default_nettype wire

// File: source/inst_decoder.sv
// instruction decoder: opcode format, immediate build and execute/memory/writeback controls
`timescale 1ns/1ps
`default_nettype none

`include "idu_cfg.svh"

module inst_decoder (
  input  decode_pkg::inst_t     inst_i,
  output decode_pkg::ctrl_t     ctrl_o,
  output decode_pkg::word_t     imm_o,
  output decode_pkg::reg_addr_t rd_o,
  output logic [`NUM_SRC-1:0]   alt_sel_o,
  output decode_pkg::funct3_t   funct3_o,
  output logic                  is_branch_o,
  output logic                  is_jal_o,
  output logic                  is_jalr_o
);

  import decode_pkg::*;

  logic [6:0] opcode;
  funct3_t    funct3;
  logic       fmt_i, fmt_u, fmt_s, fmt_j, fmt_b, fmt_r;
  word_t      imm_i, imm_u, imm_s, imm_j, imm_b;
  alu_op_t    alu_arith;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];

  assign fmt_i = (opcode == `OP_JALR) || (opcode == `OP_LOAD) || (opcode == `OP_IMM);
  assign fmt_u = (opcode == `OP_LUI) || (opcode == `OP_AUIPC);
  assign fmt_s = (opcode == `OP_STORE);
  assign fmt_j = (opcode == `OP_JAL);
  assign fmt_b = (opcode == `OP_BRANCH);
  assign fmt_r = (opcode == `OP_REG);

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  // R format and system carry no immediate
  always_comb begin
    if (fmt_i) begin
      imm_o = imm_i;
    end else if (fmt_u) begin
      imm_o = imm_u;
    end else if (fmt_s) begin
      imm_o = imm_s;
    end else if (fmt_j) begin
      imm_o = imm_j;
    end else if (fmt_b) begin
      imm_o = imm_b;
    end else begin
      imm_o = '0;
    end
  end

  // shared by op-imm and op; sub only exists in R form
  always_comb begin
    case (funct3)
      3'b000:  alu_arith = (fmt_r && inst_i[30]) ? `ALU_SUB : `ALU_ADD;
      3'b001:  alu_arith = `ALU_SLL;
      3'b010:  alu_arith = `ALU_SLT;
      3'b011:  alu_arith = `ALU_SLTU;
      3'b100:  alu_arith = `ALU_XOR;
      3'b101:  alu_arith = inst_i[30] ? `ALU_SRA : `ALU_SRL;
      3'b110:  alu_arith = `ALU_OR;
      default: alu_arith = `ALU_AND;
    endcase
  end

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.alu_op = `ALU_ADD;
    ctrl_o.wd_sel = `WD_ALU;
    case (opcode)
      `OP_LUI: begin
        ctrl_o.alu_op = `ALU_IMM;
        ctrl_o.reg_we = 1'b1;
      end
      `OP_AUIPC: begin
        ctrl_o.reg_we = 1'b1;
      end
      `OP_JAL, `OP_JALR: begin
        ctrl_o.wd_sel = `WD_PC4;
        ctrl_o.reg_we = 1'b1;
      end
      `OP_BRANCH: begin
        ctrl_o.alu_op = `ALU_SUB;
      end
      `OP_LOAD: begin
        ctrl_o.wd_sel      = `WD_MEM;
        ctrl_o.reg_we      = 1'b1;
        ctrl_o.mem_ren     = 1'b1;
        // lb and lh sign extend
        ctrl_o.load_signed = (funct3[2:1] == 2'b00);
      end
      `OP_STORE: begin
        ctrl_o.mem_wen = 1'b1;
        case (funct3[1:0])
          2'b00:   ctrl_o.wmask = 4'b0001;
          2'b01:   ctrl_o.wmask = 4'b0011;
          default: ctrl_o.wmask = 4'b1111;
        endcase
      end
      `OP_IMM, `OP_REG: begin
        ctrl_o.alu_op = alu_arith;
        ctrl_o.reg_we = 1'b1;
      end
      `OP_SYSTEM: begin
        ctrl_o.ebreak = (inst_i == `INST_EBREAK);
      end
      default: begin
      end
    endcase
  end

  assign rd_o     = inst_i[11:7];
  assign funct3_o = funct3;

  // pc feeds src1, the immediate feeds src2
  assign alt_sel_o[0] = (opcode == `OP_AUIPC) || fmt_j;
  assign alt_sel_o[1] = fmt_u || fmt_s || (opcode == `OP_LOAD) || (opcode == `OP_IMM);

  assign is_branch_o = fmt_b;
  assign is_jal_o    = fmt_j;
  assign is_jalr_o   = (opcode == `OP_JALR);

endmodule

`default_nettype wire

// File: source/src_operand.sv
// ALU source selector: alternate value, writeback forwarding or register file data
`timescale 1ns/1ps
`default_nettype none

module src_operand (
  input  decode_pkg::reg_addr_t rs_addr_i,
  input  decode_pkg::word_t     rf_data_i,
  input  logic                  alt_sel_i,
  input  decode_pkg::word_t     alt_data_i,
  input  logic                  wb_we_i,
  input  decode_pkg::reg_addr_t wb_rd_i,
  input  decode_pkg::word_t     wb_data_i,
  output decode_pkg::word_t     src_o
);

  import decode_pkg::*;

  logic fwd_hit;

  // x0 never forwards
  assign fwd_hit = wb_we_i && (wb_rd_i == rs_addr_i) && (rs_addr_i != '0);

  always_comb begin
    if (alt_sel_i) begin
      src_o = alt_data_i;
    end else if (fwd_hit) begin
      src_o = wb_data_i;
    end else begin
      src_o = rf_data_i;
    end
  end

endmodule

`default_nettype wire

// File: source/branch_resolver.sv
// branch resolver: compares sources by funct3 and picks the next program counter
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
  input  decode_pkg::word_t   pc_i,
  input  decode_pkg::word_t   src1_i,
  input  decode_pkg::word_t   src2_i,
  input  decode_pkg::word_t   imm_i,
  input  decode_pkg::funct3_t funct3_i,
  input  logic                is_branch_i,
  input  logic                is_jal_i,
  input  logic                is_jalr_i,
  output decode_pkg::word_t   pc_next_o
);

  import decode_pkg::*;

  logic  taken;
  word_t jalr_sum;

  always_comb begin
    case (funct3_i)
      3'b000:  taken = (src1_i == src2_i);
      3'b001:  taken = (src1_i != src2_i);
      3'b100:  taken = ($signed(src1_i) < $signed(src2_i));
      3'b101:  taken = ($signed(src1_i) >= $signed(src2_i));
      3'b110:  taken = (src1_i < src2_i);
      3'b111:  taken = (src1_i >= src2_i);
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = src1_i + imm_i;

  always_comb begin
    if ((is_branch_i && taken) || is_jal_i) begin
      pc_next_o = pc_i + imm_i;
    end else if (is_jalr_i) begin
      pc_next_o = jalr_sum & ~word_t'(1);
    end else begin
      pc_next_o = pc_i + word_t'(4);
    end
  end

  always_comb begin
    if (is_jalr_i) begin
      a_jalr_even: assert final (pc_next_o[0] == 1'b0)
        else $error("jalr target has bit 0 set");
    end
  end

endmodule

`default_nettype wire

// File: source/decode_out_reg.sv
// decode output stage: one-entry register with valid/ready handshake on both sides
`timescale 1ns/1ps
`default_nettype none

module decode_out_reg (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    valid_i,
  input  decode_pkg::decode_out_t data_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output decode_pkg::decode_out_t data_o,
  input  logic                    ready_i
);

  import decode_pkg::*;

  stage_state_e state_q, state_d;
  logic         load;

  // refill in the same cycle the held item drains
  assign ready_o = (state_q == IDLE) || ready_i;
  assign load    = valid_i && ready_o;
  assign valid_o = (state_q == FULL);

  always_comb begin
    state_d = state_q;
    if (load) begin
      state_d = FULL;
    end else if (ready_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      data_o  <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        data_o <= data_i;
      end
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("output changed while stalled");

endmodule

`default_nettype wire

// File: source/idu_top.sv
// decode unit top: decoder, forwarded operand selectors, branch resolver and output stage
`timescale 1ns/1ps
`default_nettype none

`include "idu_cfg.svh"

module idu_top (
  input  logic                    clk,
  input  logic                    rst,
  input  decode_pkg::inst_t       inst_i,
  input  decode_pkg::word_t       pc_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output decode_pkg::reg_addr_t   rs1_addr_o,
  output decode_pkg::reg_addr_t   rs2_addr_o,
  input  decode_pkg::word_t       rs1_data_i,
  input  decode_pkg::word_t       rs2_data_i,
  input  logic                    wb_we_i,
  input  decode_pkg::reg_addr_t   wb_rd_i,
  input  decode_pkg::word_t       wb_data_i,
  output decode_pkg::decode_out_t out_o,
  output logic                    valid_o,
  input  logic                    ready_i
);

  import decode_pkg::*;

  ctrl_t                ctrl;
  word_t                imm;
  reg_addr_t            rd;
  logic [`NUM_SRC-1:0]  alt_sel;
  funct3_t              funct3;
  logic                 is_branch, is_jal, is_jalr;
  reg_addr_t            rs_addr  [`NUM_SRC];
  word_t                rf_data  [`NUM_SRC];
  word_t                alt_data [`NUM_SRC];
  word_t                src      [`NUM_SRC];
  word_t                pc_next;
  decode_out_t          stage_in;

  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  inst_decoder u_decoder (
    .inst_i      (inst_i),
    .ctrl_o      (ctrl),
    .imm_o       (imm),
    .rd_o        (rd),
    .alt_sel_o   (alt_sel),
    .funct3_o    (funct3),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .is_jalr_o   (is_jalr)
  );

  assign rs_addr[0]  = rs1_addr_o;
  assign rs_addr[1]  = rs2_addr_o;
  assign rf_data[0]  = rs1_data_i;
  assign rf_data[1]  = rs2_data_i;
  assign alt_data[0] = pc_i;
  assign alt_data[1] = imm;

  for (genvar i = 0; i < `NUM_SRC; i++) begin : g_src
    src_operand u_src (
      .rs_addr_i  (rs_addr[i]),
      .rf_data_i  (rf_data[i]),
      .alt_sel_i  (alt_sel[i]),
      .alt_data_i (alt_data[i]),
      .wb_we_i    (wb_we_i),
      .wb_rd_i    (wb_rd_i),
      .wb_data_i  (wb_data_i),
      .src_o      (src[i])
    );
  end

  branch_resolver u_branch (
    .pc_i        (pc_i),
    .src1_i      (src[0]),
    .src2_i      (src[1]),
    .imm_i       (imm),
    .funct3_i    (funct3),
    .is_branch_i (is_branch),
    .is_jal_i    (is_jal),
    .is_jalr_i   (is_jalr),
    .pc_next_o   (pc_next)
  );

  assign stage_in = '{pc: pc_i, rd: rd, imm: imm, src1: src[0], src2: src[1],
                      ctrl: ctrl, pc_next: pc_next};

  decode_out_reg u_out_reg (
    .clk     (clk),
    .rst     (rst),
    .valid_i (valid_i),
    .data_i  (stage_in),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .data_o  (out_o),
    .ready_i (ready_i)
  );

endmodule

`default_nettype wire

// File: verif/idu_checker.sv
// decode stage checker: reference model, scoreboard queue and handshake checks
`timescale 1ns/1ps
`default_nettype none

`include "idu_cfg.svh"

module idu_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  decode_pkg::inst_t       inst_i,
  input  decode_pkg::word_t       pc_i,
  input  logic                    in_valid_i,
  input  logic                    in_ready_i,
  input  decode_pkg::reg_addr_t   rs1_addr_i,
  input  decode_pkg::reg_addr_t   rs2_addr_i,
  input  decode_pkg::word_t       rs1_data_i,
  input  decode_pkg::word_t       rs2_data_i,
  input  logic                    wb_we_i,
  input  decode_pkg::reg_addr_t   wb_rd_i,
  input  decode_pkg::word_t       wb_data_i,
  input  decode_pkg::decode_out_t out_data_i,
  input  logic                    out_valid_i,
  input  logic                    out_ready_i,
  output int                      mismatch_count_o,
  output int                      fault_count_o,
  output int                      accepted_o,
  output int                      checked_o,
  output int                      pending_o
);

  import decode_pkg::*;

  decode_out_t expected_q[$];
  decode_out_t exp_item;
  decode_out_t held_out;
  logic        held_stall = 1'b0;
  logic        rst_seen   = 1'b0;
  logic        took_item  = 1'b0;
  int          mismatches = 0;
  int          faults     = 0;
  int          accepted   = 0;
  int          checked    = 0;
  int          pending    = 0;

  assign mismatch_count_o = mismatches;
  assign fault_count_o    = faults;
  assign accepted_o       = accepted;
  assign checked_o        = checked;
  assign pending_o        = pending;

  // acceptance-cycle register read with writeback forwarding except for x0
  function automatic word_t reg_value(input reg_addr_t idx, input word_t rf_val,
                                      input logic wb_we, input reg_addr_t wb_rd,
                                      input word_t wb_data);
    if (wb_we && idx != '0 && idx == wb_rd) begin
      return wb_data;
    end
    return rf_val;
  endfunction

  function automatic alu_op_t arith_code(input funct3_t f3, input logic bit30,
                                         input logic reg_form);
    alu_op_t code;
    case (f3)
      3'b000:  code = `ALU_ADD;
      3'b001:  code = `ALU_SLL;
      3'b010:  code = `ALU_SLT;
      3'b011:  code = `ALU_SLTU;
      3'b100:  code = `ALU_XOR;
      3'b101:  code = `ALU_SRL;
      3'b110:  code = `ALU_OR;
      default: code = `ALU_AND;
    endcase
    // funct7 bit 5 selects sra, and sub in R form only
    if (bit30 && f3 == 3'b101) begin
      code = `ALU_SRA;
    end
    if (bit30 && reg_form && f3 == 3'b000) begin
      code = `ALU_SUB;
    end
    return code;
  endfunction

  function automatic decode_out_t predict(input inst_t inst, input word_t pc,
                                          input word_t rs1_val, input word_t rs2_val,
                                          input logic wb_we, input reg_addr_t wb_rd,
                                          input word_t wb_data);
    decode_out_t e;
    logic [6:0]  op;
    funct3_t     f3;
    logic        taken;
    e             = '0;
    op            = inst[6:0];
    f3            = inst[14:12];
    taken         = 1'b0;
    e.pc          = pc;
    e.rd          = inst[11:7];
    e.ctrl.alu_op = `ALU_ADD;
    e.ctrl.wd_sel = `WD_ALU;
    e.src1        = reg_value(inst[19:15], rs1_val, wb_we, wb_rd, wb_data);
    e.src2        = reg_value(inst[24:20], rs2_val, wb_we, wb_rd, wb_data);
    case (op)
      `OP_LUI, `OP_AUIPC: begin
        e.imm         = {inst[31:12], 12'h000};
        e.src2        = e.imm;
        e.ctrl.reg_we = 1'b1;
        if (op == `OP_LUI) begin
          e.ctrl.alu_op = `ALU_IMM;
        end else begin
          e.src1 = pc;
        end
      end
      `OP_JAL: begin
        e.imm         = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
        e.src1        = pc;
        e.ctrl.wd_sel = `WD_PC4;
        e.ctrl.reg_we = 1'b1;
      end
      `OP_JALR: begin
        e.imm         = 32'($signed(inst[31:20]));
        e.ctrl.wd_sel = `WD_PC4;
        e.ctrl.reg_we = 1'b1;
      end
      `OP_BRANCH: begin
        e.imm         = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        e.ctrl.alu_op = `ALU_SUB;
        case (f3)
          3'b000:  taken = (e.src1 == e.src2);
          3'b001:  taken = (e.src1 != e.src2);
          3'b100:  taken = ($signed(e.src1) < $signed(e.src2));
          3'b101:  taken = ($signed(e.src1) >= $signed(e.src2));
          3'b110:  taken = (e.src1 < e.src2);
          3'b111:  taken = (e.src1 >= e.src2);
          default: taken = 1'b0;
        endcase
      end
      `OP_LOAD: begin
        e.imm              = 32'($signed(inst[31:20]));
        e.src2             = e.imm;
        e.ctrl.wd_sel      = `WD_MEM;
        e.ctrl.reg_we      = 1'b1;
        e.ctrl.mem_ren     = 1'b1;
        e.ctrl.load_signed = (f3 == 3'd0 || f3 == 3'd1);
      end
      `OP_STORE: begin
        e.imm          = 32'($signed({inst[31:25], inst[11:7]}));
        e.src2         = e.imm;
        e.ctrl.mem_wen = 1'b1;
        e.ctrl.wmask   = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
      end
      `OP_IMM: begin
        e.imm         = 32'($signed(inst[31:20]));
        e.src2        = e.imm;
        e.ctrl.alu_op = arith_code(f3, inst[30], 1'b0);
        e.ctrl.reg_we = 1'b1;
      end
      `OP_REG: begin
        e.ctrl.alu_op = arith_code(f3, inst[30], 1'b1);
        e.ctrl.reg_we = 1'b1;
      end
      `OP_SYSTEM: begin
        e.ctrl.ebreak = (inst == `INST_EBREAK);
      end
      default: begin
      end
    endcase
    if ((op == `OP_BRANCH && taken) || op == `OP_JAL) begin
      e.pc_next = pc + e.imm;
    end else if (op == `OP_JALR) begin
      e.pc_next = (e.src1 + e.imm) & 32'hFFFF_FFFE;
    end else begin
      e.pc_next = pc + 32'd4;
    end
    return e;
  endfunction

  task automatic report_fault(input string what);
    $display("Error at %0t: %s", $time, what);
    faults++;
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
      mismatches++;
    end
  endtask

  task automatic compare_item(input decode_out_t want, input decode_out_t got);
    compare_field("out_o.pc", want.pc, got.pc);
    compare_field("out_o.rd", 32'(want.rd), 32'(got.rd));
    compare_field("out_o.imm", want.imm, got.imm);
    compare_field("out_o.src1", want.src1, got.src1);
    compare_field("out_o.src2", want.src2, got.src2);
    compare_field("out_o.ctrl.alu_op", 32'(want.ctrl.alu_op), 32'(got.ctrl.alu_op));
    compare_field("out_o.ctrl.wd_sel", 32'(want.ctrl.wd_sel), 32'(got.ctrl.wd_sel));
    compare_field("out_o.ctrl.reg_we", 32'(want.ctrl.reg_we), 32'(got.ctrl.reg_we));
    compare_field("out_o.ctrl.mem_ren", 32'(want.ctrl.mem_ren), 32'(got.ctrl.mem_ren));
    compare_field("out_o.ctrl.mem_wen", 32'(want.ctrl.mem_wen), 32'(got.ctrl.mem_wen));
    compare_field("out_o.ctrl.wmask", 32'(want.ctrl.wmask), 32'(got.ctrl.wmask));
    compare_field("out_o.ctrl.load_signed", 32'(want.ctrl.load_signed),
                  32'(got.ctrl.load_signed));
    compare_field("out_o.ctrl.ebreak", 32'(want.ctrl.ebreak), 32'(got.ctrl.ebreak));
    compare_field("out_o.pc_next", want.pc_next, got.pc_next);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      expected_q.delete();
      rst_seen   = 1'b1;
      held_stall = 1'b0;
      pending    = 0;
    end else begin
      if (rst_seen && (out_valid_i || !in_ready_i || out_data_i != '0)) begin
        report_fault("stage not empty with ready_o high after reset");
      end
      // the queue holds exactly what the stage should hold before this edge
      if (in_ready_i != (expected_q.size() == 0 || out_ready_i)) begin
        report_fault("ready_o does not follow the stage occupancy and ready_i");
      end
      if (out_valid_i != (expected_q.size() != 0)) begin
        report_fault("valid_o does not match the number of items held");
      end
      if (held_stall && (!out_valid_i || out_data_i != held_out)) begin
        report_fault("output dropped or changed while stalled");
      end
      if (out_valid_i && out_ready_i) begin
        if (expected_q.size() == 0) begin
          report_fault("output transfer with no accepted item pending");
        end else begin
          exp_item = expected_q.pop_front();
          compare_item(exp_item, out_data_i);
          checked++;
        end
      end
      took_item = in_valid_i && in_ready_i;
      if (took_item) begin
        compare_field("rs1_addr_o", 32'(inst_i[19:15]), 32'(rs1_addr_i));
        compare_field("rs2_addr_o", 32'(inst_i[24:20]), 32'(rs2_addr_i));
        expected_q.push_back(predict(inst_i, pc_i, rs1_data_i, rs2_data_i,
                                     wb_we_i, wb_rd_i, wb_data_i));
        accepted++;
      end
      held_stall = out_valid_i && !out_ready_i;
      held_out   = out_data_i;
      rst_seen   = 1'b0;
      pending    = expected_q.size();
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_idu.sv
// decode stage testbench: clock, reset, random RV32I stimulus and end-of-run report
`timescale 1ns/1ps
`default_nettype none

`include "idu_cfg.svh"

module tb_idu;

  import decode_pkg::*;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_ITEMS    = 2000;
  localparam int          WATCHDOG_NS  = NUM_ITEMS * 4 * CLK_PERIOD;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic        clk;
  logic        rst;
  inst_t       inst_i;
  word_t       pc_i;
  logic        valid_i;
  logic        ready_o;
  reg_addr_t   rs1_addr_o;
  reg_addr_t   rs2_addr_o;
  word_t       rs1_data_i;
  word_t       rs2_data_i;
  logic        wb_we_i;
  reg_addr_t   wb_rd_i;
  word_t       wb_data_i;
  decode_out_t out_o;
  logic        valid_o;
  logic        ready_i;
  int          mismatches;
  int          faults;
  int          accepted;
  int          checked;
  int          pending;
  logic [31:0] lfsr_state;

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] take_bits(input int unsigned count);
    logic [31:0] value;
    logic        out_bit;
    value = '0;
    for (int unsigned k = 0; k < count; k++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      value = {value[30:0], out_bit};
    end
    return value;
  endfunction

  // legal RV32I encoding with random register fields and immediates
  function automatic inst_t make_inst();
    logic [31:0] r;
    logic [3:0]  kind;
    funct3_t     f3;
    logic [6:0]  f7;
    inst_t       inst;
    r    = take_bits(32);
    kind = 4'(take_bits(4) % 10);
    f3   = r[14:12];
    f7   = 7'b0;
    case (kind)
      4'd0: inst = {r[31:12], r[11:7], `OP_LUI};
      4'd1: inst = {r[31:12], r[11:7], `OP_AUIPC};
      4'd2: inst = {r[31:7], `OP_JAL};
      4'd3: inst = {r[31:15], 3'b000, r[11:7], `OP_JALR};
      4'd4: begin
        // 010 and 011 are not branch codes
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        inst = {r[31:15], f3, r[11:7], `OP_BRANCH};
      end
      4'd5: begin
        if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7) begin
          f3 = 3'd2;
        end
        inst = {r[31:15], f3, r[11:7], `OP_LOAD};
      end
      4'd6: begin
        f3   = {1'b0, (r[13:12] == 2'b11) ? 2'b10 : r[13:12]};
        inst = {r[31:15], f3, r[11:7], `OP_STORE};
      end
      4'd7: begin
        f7 = r[31:25];
        // shift immediates keep funct7 legal
        if (f3 == 3'd1 || f3 == 3'd5) begin
          f7 = {1'b0, r[30] & f3[2], 5'b0};
        end
        inst = {f7, r[24:15], f3, r[11:7], `OP_IMM};
      end
      4'd8: begin
        if (f3 == 3'd0 || f3 == 3'd5) begin
          f7 = {1'b0, r[30], 5'b0};
        end
        inst = {f7, r[24:15], f3, r[11:7], `OP_REG};
      end
      default: inst = r[0] ? `INST_EBREAK : 32'h0000_0073;
    endcase
    return inst;
  endfunction

  task automatic drive_random();
    logic [2:0] pick;
    valid_i    = (take_bits(2) != 0);
    ready_i    = (take_bits(2) != 0);
    inst_i     = make_inst();
    pc_i       = take_bits(30) << 2;
    rs1_data_i = take_bits(32);
    pick       = 3'(take_bits(3));
    // equal operands now and then so branches go both ways
    rs2_data_i = (pick == 3'd0) ? rs1_data_i : take_bits(32);
    wb_we_i    = (take_bits(1) != 0);
    pick       = 3'(take_bits(3));
    case (pick)
      3'd0:    wb_rd_i = inst_i[19:15];
      3'd1:    wb_rd_i = inst_i[24:20];
      default: wb_rd_i = 5'(take_bits(5));
    endcase
    wb_data_i  = take_bits(32);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  idu_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .inst_i     (inst_i),
    .pc_i       (pc_i),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .rs1_addr_o (rs1_addr_o),
    .rs2_addr_o (rs2_addr_o),
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .wb_we_i    (wb_we_i),
    .wb_rd_i    (wb_rd_i),
    .wb_data_i  (wb_data_i),
    .out_o      (out_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i)
  );

  idu_checker u_checker (
    .clk              (clk),
    .rst              (rst),
    .inst_i           (inst_i),
    .pc_i             (pc_i),
    .in_valid_i       (valid_i),
    .in_ready_i       (ready_o),
    .rs1_addr_i       (rs1_addr_o),
    .rs2_addr_i       (rs2_addr_o),
    .rs1_data_i       (rs1_data_i),
    .rs2_data_i       (rs2_data_i),
    .wb_we_i          (wb_we_i),
    .wb_rd_i          (wb_rd_i),
    .wb_data_i        (wb_data_i),
    .out_data_i       (out_o),
    .out_valid_i      (valid_o),
    .out_ready_i      (ready_i),
    .mismatch_count_o (mismatches),
    .fault_count_o    (faults),
    .accepted_o       (accepted),
    .checked_o        (checked),
    .pending_o        (pending)
  );

  initial begin
    $timeformat(-9, 0, " ns", 0);
    lfsr_state = 32'd59;
    rst        = 1'b1;
    inst_i     = '0;
    pc_i       = '0;
    valid_i    = 1'b0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    wb_we_i    = 1'b0;
    wb_rd_i    = '0;
    wb_data_i  = '0;
    ready_i    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (accepted < NUM_ITEMS) begin
      drive_random();
      @(negedge clk);
    end
    // drain whatever is still held in the stage
    valid_i = 1'b0;
    ready_i = 1'b1;
    while (pending != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures (%0d items accepted, %0d checked)",
             mismatches, faults, accepted, checked);
    if (mismatches == 0 && faults == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("errors: %0d mismatches, %0d other failures (%0d items accepted, %0d checked)",
             mismatches, faults, accepted, checked);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/decode_pkg.sv
source/inst_decoder.sv
source/src_operand.sv
source/branch_resolver.sv
source/decode_out_reg.sv
source/idu_top.sv
verif/idu_checker.sv
verif/tb_idu.sv

// File: run.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

mkdir -p build &&
  verilator --binary --timing --assert -f project.f --top-module tb_idu \
    -Mdir build > build/compile.log 2>&1 &&
  ./build/Vtb_idu | tee build/sim.log &&
  grep -qx "TESTBENCH PASSED" build/sim.log ||
  { echo "build or simulation did not pass, see build/"; exit 1; }
